// File: Bender.yml
package:
  name: scalar_pipe

sources:
  - files:
      - logic/coreIsaPkg.sv
      - logic/corePipePkg.sv
      - logic/fetchUnit.sv
      - logic/decodeUnit.sv
      - logic/regFile.sv
      - logic/execAlu.sv
      - logic/execMul.sv
      - logic/execUnit.sv
  - target: test
    files:
      - testbench/tbExecUnit.sv

// File: logic/coreIsaPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set definitions for the scalar core
// Field widths, opcode values, register zero and the PC step
// Instruction word as a packed union with register and immediate views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package coreIsaPkg;

	localparam int instrWidth  = 16;
	localparam int regIdWidth  = 4;	// 16 registers
	localparam int immWidth    = 8;
	localparam int opcodeWidth = 4;

	// Opcodes, all other values act as NOP
	localparam logic [opcodeWidth-1:0] opNop  = 4'd0;
	localparam logic [opcodeWidth-1:0] opAdd  = 4'd1;
	localparam logic [opcodeWidth-1:0] opSub  = 4'd2;
	localparam logic [opcodeWidth-1:0] opAnd  = 4'd3;
	localparam logic [opcodeWidth-1:0] opOr   = 4'd4;
	localparam logic [opcodeWidth-1:0] opXor  = 4'd5;
	localparam logic [opcodeWidth-1:0] opShl  = 4'd6;	// rs << rt, low bits of rt
	localparam logic [opcodeWidth-1:0] opMul  = 4'd7;	// Low word of product
	localparam logic [opcodeWidth-1:0] opMovi = 4'd8;
	localparam logic [opcodeWidth-1:0] opAddi = 4'd9;
	localparam logic [opcodeWidth-1:0] opBra  = 4'd10;	// PC + 2 * simm

	localparam logic [regIdWidth-1:0] zeroReg = '0;	// Reads zero, drops writes

	localparam int unsigned pcStep = 2;	// Bytes per instruction

	// Slot numbers inside the two views
	localparam int opcodeField = 3;
	localparam int rnField     = 2;
	localparam int rsField     = 1;
	localparam int rtField     = 0;
	localparam int immField    = 0;	// Low byte of the immediate view

	// Upper slot of the immediate view holds {opcode, rn}
	typedef union packed
	{
		logic [instrWidth/regIdWidth-1:0][regIdWidth-1:0] regView;
		logic [instrWidth/immWidth-1:0][immWidth-1:0]     immView;
	} instrWord;

endpackage

// File: logic/corePipePkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline internal definitions
// ALU operation codes and the default reset PC
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package corePipePkg;

	localparam int aluOpWidth = 3;

	// Internal ALU operations, set by decode
	localparam logic [aluOpWidth-1:0] aluAdd   = 3'd0;
	localparam logic [aluOpWidth-1:0] aluSub   = 3'd1;
	localparam logic [aluOpWidth-1:0] aluAnd   = 3'd2;
	localparam logic [aluOpWidth-1:0] aluOr    = 3'd3;
	localparam logic [aluOpWidth-1:0] aluXor   = 3'd4;
	localparam logic [aluOpWidth-1:0] aluShl   = 3'd5;
	localparam logic [aluOpWidth-1:0] aluPassB = 3'd6;	// MOVI result

	localparam int unsigned resetPcDefault = 0;

endpackage

// File: logic/decodeUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID1 decode and ID2 latch
// Splits the instruction word into register ids, immediate and ALU code
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module decodeUnit #(
	parameter int dataWidth = 32
)(
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  hold,
	input  logic                                  freeze,
	input  logic                                  squash,
	input  coreIsaPkg::instrWord                  id1Word,
	input  logic [dataWidth-1:0]                  id1Pc,
	input  logic                                  id1Valid,
	output logic [coreIsaPkg::regIdWidth-1:0]     srcA,
	output logic [coreIsaPkg::regIdWidth-1:0]     srcB,
	output logic [coreIsaPkg::regIdWidth-1:0]     dest,
	output logic [dataWidth-1:0]                  imm,
	output logic [corePipePkg::aluOpWidth-1:0]    aluOp,
	output logic                                  useImm,
	output logic                                  writesReg,
	output logic                                  isMul,
	output logic                                  isBranch,
	output logic [dataWidth-1:0]                  id2Pc,
	output logic                                  id2Valid
);
	import coreIsaPkg::*;
	import corePipePkg::*;

	logic [opcodeWidth-1:0] opcode;
	logic [regIdWidth-1:0]  fieldRn;
	logic [regIdWidth-1:0]  fieldRs;
	logic [regIdWidth-1:0]  fieldRt;
	logic [immWidth-1:0]    fieldImm;
	logic [dataWidth-1:0]   immExt;
	logic [regIdWidth-1:0]  decSrcA;
	logic [regIdWidth-1:0]  decSrcB;
	logic [aluOpWidth-1:0]  decAluOp;
	logic                   decUseImm;
	logic                   decWritesReg;
	logic                   decIsMul;
	logic                   decIsBranch;
	logic                   advance;

	// Register view
	assign opcode  = id1Word.regView[opcodeField];
	assign fieldRn = id1Word.regView[rnField];
	assign fieldRs = id1Word.regView[rsField];
	assign fieldRt = id1Word.regView[rtField];

	assign fieldImm = id1Word.immView[immField];	// Immediate view
	assign immExt   = {{(dataWidth-immWidth){fieldImm[immWidth-1]}}, fieldImm};

	always_comb
	begin
		decSrcA      = zeroReg;	// Unused sources read r0 and never interlock
		decSrcB      = zeroReg;
		decAluOp     = aluAdd;
		decUseImm    = 1'b0;
		decWritesReg = 1'b0;
		decIsMul     = 1'b0;
		decIsBranch  = 1'b0;
		case (opcode)
			opAdd, opSub, opAnd, opOr, opXor, opShl, opMul:
			begin
				decSrcA      = fieldRs;
				decSrcB      = fieldRt;
				decWritesReg = 1'b1;
				decIsMul     = (opcode == opMul);
				case (opcode)
					opSub:   decAluOp = aluSub;
					opAnd:   decAluOp = aluAnd;
					opOr:    decAluOp = aluOr;
					opXor:   decAluOp = aluXor;
					opShl:   decAluOp = aluShl;
					default: decAluOp = aluAdd;	// MUL ignores it
				endcase
			end
			opMovi:
			begin
				decAluOp     = aluPassB;
				decUseImm    = 1'b1;
				decWritesReg = 1'b1;
			end
			opAddi:
			begin
				decSrcA      = fieldRn;	// rn is source and destination
				decUseImm    = 1'b1;
				decWritesReg = 1'b1;
			end
			opBra:
				decIsBranch = 1'b1;
			default:
				decWritesReg = 1'b0;
		endcase
	end

	assign advance = !freeze && !hold && !squash;

	always_ff @(posedge clock)
	begin
		if (reset)
			id2Valid <= 1'b0;
		else if (!freeze)
		begin
			if (squash)
				id2Valid <= 1'b0;	// Younger than the taken branch
			else if (!hold)
				id2Valid <= id1Valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			srcA      <= decSrcA;
			srcB      <= decSrcB;
			dest      <= fieldRn;
			imm       <= immExt;
			aluOp     <= decAluOp;
			useImm    <= decUseImm;
			writesReg <= decWritesReg;
			isMul     <= decIsMul;
			isBranch  <= decIsBranch;
			id2Pc     <= id1Pc;
		end
	end

endmodule

// File: logic/execAlu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX1 integer ALU
// Add, subtract, logic ops, left shift, pass-through
// PC-relative branch target
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module execAlu #(
	parameter int dataWidth = 32
)(
	input  logic [corePipePkg::aluOpWidth-1:0] aluOp,
	input  logic [dataWidth-1:0]               opA,
	input  logic [dataWidth-1:0]               opB,
	input  logic [dataWidth-1:0]               pc,
	input  logic [dataWidth-1:0]               imm,
	output logic [dataWidth-1:0]               result,
	output logic [dataWidth-1:0]               branchTarget
);
	import corePipePkg::*;

	localparam int shiftBits = $clog2(dataWidth);

	always_comb
	begin
		case (aluOp)
			aluAdd:   result = opA + opB;
			aluSub:   result = opA - opB;
			aluAnd:   result = opA & opB;
			aluOr:    result = opA | opB;
			aluXor:   result = opA ^ opB;
			aluShl:   result = opA << opB[shiftBits-1:0];	// Low bits only
			aluPassB: result = opB;
			default:  result = '0;
		endcase
	end

	// Offset counts instructions, not bytes
	assign branchTarget = pc + {imm[dataWidth-2:0], 1'b0};

endmodule

// File: logic/execMul.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage multiplier, low word of the product
// Partial products registered at the end of EX1, summed in EX2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module execMul #(
	parameter int dataWidth = 32
)(
	input  logic                 clock,
	input  logic                 advance,
	input  logic [dataWidth-1:0] opA,
	input  logic [dataWidth-1:0] opB,
	output logic [dataWidth-1:0] product
);
	localparam int halfWidth = dataWidth / 2;

	logic [dataWidth-1:0] partLow;	// aLow * b
	logic [halfWidth-1:0] partHigh;	// aHigh * bLow, only bits inside the low word

	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			partLow  <= dataWidth'(opA[halfWidth-1:0]) * opB;
			partHigh <= opA[dataWidth-1:halfWidth] * opB[halfWidth-1:0];
		end
	end

	assign product = partLow + {partHigh, {halfWidth{1'b0}}};

endmodule

// File: logic/execUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Six-stage scalar pipeline top, IF ID1 ID2 EX1 EX2 WB
// EX1 and EX2 stage registers, multiply interlock, branch squash
// Whole-pipeline freeze on fetch wait, writeback port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module execUnit #(
	parameter int dataWidth = 32,
	parameter logic [dataWidth-1:0] resetPc = dataWidth'(corePipePkg::resetPcDefault)
)(
	input  logic                              clock,
	input  logic                              reset,
	output logic [dataWidth-1:0]              fetchAddr,
	input  coreIsaPkg::instrWord              fetchData,
	input  logic                              fetchWait,
	output logic                              wbValid,
	output logic [coreIsaPkg::regIdWidth-1:0] wbReg,
	output logic [dataWidth-1:0]              wbValue
);
	import coreIsaPkg::*;
	import corePipePkg::*;

	logic                  freeze;
	logic                  hold;
	logic                  branchTaken;
	logic [dataWidth-1:0]  branchTarget;

	instrWord              id1Word;
	logic [dataWidth-1:0]  id1Pc;
	logic                  id1Valid;

	logic [regIdWidth-1:0] id2SrcA;
	logic [regIdWidth-1:0] id2SrcB;
	logic [regIdWidth-1:0] id2Dest;
	logic [dataWidth-1:0]  id2Imm;
	logic [aluOpWidth-1:0] id2AluOp;
	logic                  id2UseImm;
	logic                  id2WritesReg;
	logic                  id2IsMul;
	logic                  id2IsBranch;
	logic [dataWidth-1:0]  id2Pc;
	logic                  id2Valid;
	logic [dataWidth-1:0]  id2ValA;
	logic [dataWidth-1:0]  id2ValB;

	logic                  ex1Valid;
	logic [regIdWidth-1:0] ex1Dest;
	logic                  ex1WritesReg;
	logic                  ex1IsMul;
	logic                  ex1IsBranch;
	logic [aluOpWidth-1:0] ex1AluOp;
	logic [dataWidth-1:0]  ex1OpA;
	logic [dataWidth-1:0]  ex1OpB;
	logic [dataWidth-1:0]  ex1Pc;
	logic [dataWidth-1:0]  ex1Imm;
	logic [dataWidth-1:0]  ex1AluResult;
	logic                  fwdValid;

	logic                  ex2Valid;
	logic [regIdWidth-1:0] ex2Dest;
	logic                  ex2WritesReg;
	logic                  ex2IsMul;
	logic [dataWidth-1:0]  ex2AluResult;
	logic [dataWidth-1:0]  mulProduct;
	logic [dataWidth-1:0]  commitValue;
	logic                  commitEnable;

	assign freeze = fetchWait;

	// Consumer right behind a multiply waits one cycle for the EX2 product
	assign hold = id2Valid && ex1Valid && ex1IsMul && ex1Dest != zeroReg
		&& (id2SrcA == ex1Dest || id2SrcB == ex1Dest);

	assign branchTaken = ex1Valid && ex1IsBranch;
	assign fwdValid    = ex1Valid && ex1WritesReg && !ex1IsMul;	// Product not ready in EX1

	fetchUnit #(.dataWidth(dataWidth), .resetPc(resetPc)) u_fetch (
		.clock(clock), .reset(reset), .hold(hold), .freeze(freeze),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.fetchData(fetchData), .fetchAddr(fetchAddr),
		.id1Word(id1Word), .id1Pc(id1Pc), .id1Valid(id1Valid)
	);

	decodeUnit #(.dataWidth(dataWidth)) u_decode (
		.clock(clock), .reset(reset), .hold(hold), .freeze(freeze), .squash(branchTaken),
		.id1Word(id1Word), .id1Pc(id1Pc), .id1Valid(id1Valid),
		.srcA(id2SrcA), .srcB(id2SrcB), .dest(id2Dest), .imm(id2Imm), .aluOp(id2AluOp),
		.useImm(id2UseImm), .writesReg(id2WritesReg), .isMul(id2IsMul),
		.isBranch(id2IsBranch), .id2Pc(id2Pc), .id2Valid(id2Valid)
	);

	regFile #(.dataWidth(dataWidth)) u_regs (
		.clock(clock), .reset(reset),
		.readIdA(id2SrcA), .readIdB(id2SrcB), .readValA(id2ValA), .readValB(id2ValB),
		.fwdId(ex1Dest), .fwdVal(ex1AluResult), .fwdValid(fwdValid),
		.commitId(ex2Dest), .commitVal(commitValue), .commitEnable(commitEnable)
	);

	execAlu #(.dataWidth(dataWidth)) u_alu (
		.aluOp(ex1AluOp), .opA(ex1OpA), .opB(ex1OpB), .pc(ex1Pc), .imm(ex1Imm),
		.result(ex1AluResult), .branchTarget(branchTarget)
	);

	execMul #(.dataWidth(dataWidth)) u_mul (
		.clock(clock), .advance(!freeze), .opA(ex1OpA), .opB(ex1OpB), .product(mulProduct)
	);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex1Valid <= 1'b0;
			ex2Valid <= 1'b0;
		end
		else if (!freeze)
		begin
			ex1Valid <= id2Valid && !hold && !branchTaken;	// Bubble on interlock or squash
			ex2Valid <= ex1Valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!freeze)
		begin
			ex1Dest      <= id2Dest;
			ex1WritesReg <= id2WritesReg;
			ex1IsMul     <= id2IsMul;
			ex1IsBranch  <= id2IsBranch;
			ex1AluOp     <= id2AluOp;
			ex1OpA       <= id2ValA;
			ex1OpB       <= id2UseImm ? id2Imm : id2ValB;
			ex1Pc        <= id2Pc;
			ex1Imm       <= id2Imm;
			ex2Dest      <= ex1Dest;
			ex2WritesReg <= ex1WritesReg;
			ex2IsMul     <= ex1IsMul;
			ex2AluResult <= ex1AluResult;
		end
	end

	// Commit at the end of EX2
	assign commitValue  = ex2IsMul ? mulProduct : ex2AluResult;
	assign commitEnable = ex2Valid && ex2WritesReg && ex2Dest != zeroReg && !freeze;

	assign wbValid = commitEnable;
	assign wbReg   = ex2Dest;
	assign wbValue = commitValue;

endmodule

// File: logic/fetchUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IF stage
// PC register with sequential step and branch redirect
// IF to ID1 latch for instruction word, PC and valid
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module fetchUnit #(
	parameter int dataWidth = 32,
	parameter logic [dataWidth-1:0] resetPc = '0
)(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 hold,
	input  logic                 freeze,
	input  logic                 branchTaken,
	input  logic [dataWidth-1:0] branchTarget,
	input  coreIsaPkg::instrWord fetchData,
	output logic [dataWidth-1:0] fetchAddr,
	output coreIsaPkg::instrWord id1Word,
	output logic [dataWidth-1:0] id1Pc,
	output logic                 id1Valid
);
	import coreIsaPkg::*;

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] nextPc;
	logic                 accept;	// Word on fetchData moves into ID1

	assign fetchAddr = pc;
	assign nextPc    = pc + dataWidth'(pcStep);
	assign accept    = !freeze && !hold && !branchTaken;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc       <= resetPc;
			id1Valid <= 1'b0;
		end
		else if (!freeze)
		begin
			if (branchTaken)
			begin
				// Current fetch is dropped, ID1 becomes a bubble
				pc       <= branchTarget;
				id1Valid <= 1'b0;
			end
			else if (!hold)
			begin
				pc       <= nextPc;
				id1Valid <= 1'b1;	// Fetch always completes in the same cycle
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			id1Word <= fetchData;
			id1Pc   <= pc;
		end
	end

endmodule

// File: logic/regFile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General register file, 16 entries
// Commit write from EX2, two read ports with EX1 and EX2 bypass
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module regFile #(
	parameter int dataWidth = 32
)(
	input  logic                              clock,
	input  logic                              reset,
	input  logic [coreIsaPkg::regIdWidth-1:0] readIdA,
	input  logic [coreIsaPkg::regIdWidth-1:0] readIdB,
	output logic [dataWidth-1:0]              readValA,
	output logic [dataWidth-1:0]              readValB,
	input  logic [coreIsaPkg::regIdWidth-1:0] fwdId,
	input  logic [dataWidth-1:0]              fwdVal,
	input  logic                              fwdValid,
	input  logic [coreIsaPkg::regIdWidth-1:0] commitId,
	input  logic [dataWidth-1:0]              commitVal,
	input  logic                              commitEnable
);
	import coreIsaPkg::*;

	logic [dataWidth-1:0] regs [2**regIdWidth];

	// Youngest producer wins
	function automatic logic [dataWidth-1:0] readPort(input logic [regIdWidth-1:0] id);
		logic [dataWidth-1:0] value;
		if (id == zeroReg)
			value = '0;
		else if (fwdValid && id == fwdId)
			value = fwdVal;	// EX1 ALU result
		else if (commitEnable && id == commitId)
			value = commitVal;	// Being written this cycle
		else
			value = regs[id];
		return value;
	endfunction

	always_comb
	begin
		readValA = readPort(readIdA);
		readValB = readPort(readIdB);
	end

	// r0 is never stored
	always_ff @(posedge clock)
	begin
		if (commitEnable && !reset && commitId != zeroReg)
			regs[commitId] <= commitVal;
	end

endmodule

// File: project.f
logic/coreIsaPkg.sv
logic/corePipePkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/execAlu.sv
logic/execMul.sv
logic/execUnit.sv
testbench/tbExecUnit.sv

// File: testbench/tbExecUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the six-stage scalar pipeline
// Program table served on the fetch port, expected commit table
// Two runs with steady fetch and with random fetch wait from an xorshift source
// Reset checks, in-order writeback checks, idle tail and cycle timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tbExecUnit;
	import coreIsaPkg::*;

	localparam int halfPeriod   = 20;
	localparam int resetCycles  = 16;
	localparam int tailCycles   = 24;	// Quiet cycles after the last write
	localparam int progLen      = 23;
	localparam int expLen       = 17;
	localparam int timeoutLimit = 4 * progLen + resetCycles + 64;
	localparam logic [31:0] resetPc = 32'h0;
	localparam logic [31:0] seed    = 32'h5991_12ac;

	// Layout {opcode, rn, rs, rt} or {opcode, rn, imm8}
	localparam logic [0:progLen-1][15:0] progTable = {
		16'h8105,	// MOVI r1, 5
		16'h82FD,	// MOVI r2, -3
		16'h1312,	// ADD  r3, r1, r2
		16'h2431,	// SUB  r4, r3, r1
		16'h3541,	// AND  r5, r4, r1
		16'h4653,	// OR   r6, r5, r3
		16'h5764,	// XOR  r7, r6, r4
		16'h6863,	// SHL  r8, r6, r3
		16'h9864,	// ADDI r8, 100
		16'h7978,	// MUL  r9, r7, r8 with a negative first operand
		16'h1A91,	// ADD  r10, r9, r1 right behind the multiply
		16'h7B11,	// MUL  r11, r1, r1
		16'h8055,	// MOVI r0, 0x55 is discarded
		16'h1C0B,	// ADD  r12, r0, r11
		16'hA005,	// BRA  +5 to word 19
		16'h8D11,	// Squashed
		16'h8E22,	// Squashed
		16'h8F33,	// Squashed
		16'h8D44,	// Jumped over
		16'h8D7F,	// MOVI r13, 0x7f
		16'h9D80,	// ADDI r13, -128
		16'h1EDC,	// ADD  r14, r13, r12
		16'h6FE3	// SHL  r15, r14, r3
	};

	// Register and value of each commit in program order
	localparam logic [0:expLen-1][regIdWidth+31:0] expTable = {
		{4'd1,  32'h0000_0005},
		{4'd2,  32'hFFFF_FFFD},
		{4'd3,  32'h0000_0002},
		{4'd4,  32'hFFFF_FFFD},
		{4'd5,  32'h0000_0005},
		{4'd6,  32'h0000_0007},
		{4'd7,  32'hFFFF_FFFA},
		{4'd8,  32'h0000_001C},
		{4'd8,  32'h0000_0080},
		{4'd9,  32'hFFFF_FD00},	// -6 * 128
		{4'd10, 32'hFFFF_FD05},
		{4'd11, 32'h0000_0019},
		{4'd12, 32'h0000_0019},	// r0 reads as zero
		{4'd13, 32'h0000_007F},
		{4'd13, 32'hFFFF_FFFF},
		{4'd14, 32'h0000_0018},
		{4'd15, 32'h0000_0060}
	};

	logic                  clock;
	logic                  reset;
	logic                  fetchWait;
	logic [31:0]           fetchAddr;
	instrWord              fetchData;
	logic                  wbValid;
	logic [regIdWidth-1:0] wbReg;
	logic [31:0]           wbValue;

	logic                  randomWait;
	logic [31:0]           rngState = seed;
	int                    cycleCount = 0;

	execUnit #(.dataWidth(32), .resetPc(resetPc)) u_dut (
		.clock(clock), .reset(reset),
		.fetchAddr(fetchAddr), .fetchData(fetchData), .fetchWait(fetchWait),
		.wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue)
	);

	always #halfPeriod clock = ~clock;

	// Instruction memory returns NOP past the end
	always_comb
	begin
		if (fetchAddr < 2 * progLen)
			fetchData = progTable[fetchAddr[31:1]];
		else
			fetchData = {opNop, 12'h000};
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Fetch port stalls roughly three cycles in eight
	always @(posedge clock)
	begin
		if (randomWait)
		begin
			rngState = nextRandom(rngState);
			fetchWait <= (rngState[2:0] < 3'd3);
		end
		else
			fetchWait <= 1'b0;
	end

	always @(posedge clock)
	begin
		if (reset)
			cycleCount <= 0;
		else
			cycleCount <= cycleCount + 1;
		if (cycleCount > timeoutLimit)
		begin
			$display("Timeout: the expected writebacks did not arrive within %0d cycles",
				timeoutLimit);
			$display("Errors found");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// Resets the DUT, walks the expected commits and watches a quiet tail
	task automatic runProgram(input logic withWait);
		int cycle;
		int writeIdx;
		@(posedge clock);
		reset      <= 1'b1;
		randomWait <= withWait;
		for (cycle = 0; cycle < resetCycles; cycle++)
		begin
			@(posedge clock);
			if (cycle == resetCycles - 1)
				reset <= 1'b0;	// Last check lands in the first cycle out of reset
			@(negedge clock);
			checkValue("wbValid", wbValid, 0);
			checkValue("fetchAddr", fetchAddr, resetPc);
		end
		for (writeIdx = 0; writeIdx < expLen; writeIdx++)
		begin
			@(negedge clock);
			while (wbValid !== 1'b1)
				@(negedge clock);
			checkValue("wbReg", wbReg, expTable[writeIdx][regIdWidth+31:32]);
			checkValue("wbValue", wbValue, expTable[writeIdx][31:0]);
		end
		repeat (tailCycles)
		begin
			@(negedge clock);
			checkValue("wbValid", wbValid, 0);	// No extra or repeated commit
		end
	endtask

	initial
	begin
		clock      = 1'b0;
		reset      = 1'b1;
		fetchWait  = 1'b0;
		randomWait = 1'b0;
		runProgram(1'b0);	// Steady fetch
		runProgram(1'b1);	// Random fetch wait
		$display("No errors");
		$finish;
	end

endmodule
